// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exe
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "run reported failure"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: exe_commit.sv
`default_nettype none

module exe_commit
	import exe_pkg::*;
#(
	parameter int xlen = 32
) (
	input  wire logic clk,
	input  wire logic nrst,
	exe_op_if.commit op,
	input  wire logic [xlen-1:0] result,
	input  wire priv_mode_t mode,
	input  wire logic m_timer,
	input  wire logic s_timer,
	input  wire logic u_timer,
	input  wire logic ext_irq, // one external line for all modes
	input  wire logic m_tie,
	input  wire logic s_tie,
	input  wire logic u_tie,
	input  wire logic m_eie,
	input  wire logic s_eie,
	input  wire logic u_eie,
	output logic [xlen-1:0] wb_data,
	output logic [4:0] wb_rd,
	output logic wb_we,
	output logic trap,
	output logic [xlen-1:0] cause,
	output logic [xlen-1:0] trap_pc
);

	logic [xlen-1:0] result_q;
	logic [xlen-1:0] pc_q;
	logic [4:0] rd_q;
	logic we_q;
	logic misaligned_q;
	logic illegal_q;
	logic ecall_q;
	logic ebreak_q;

	logic m_tim;
	logic s_tim;
	logic u_tim;
	logic m_ext;
	logic s_ext;
	logic u_ext;
	logic is_irq;
	logic [3:0] code;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			result_q     <= '0;
			pc_q         <= '0;
			rd_q         <= '0;
			we_q         <= 1'b0;
			misaligned_q <= 1'b0;
			illegal_q    <= 1'b0;
			ecall_q      <= 1'b0;
			ebreak_q     <= 1'b0;
		end
		else
		begin
			result_q     <= trap ? '0 : result;
			pc_q         <= trap ? '0 : op.pc;
			rd_q         <= trap ? 5'd0 : op.rd;
			we_q         <= op.we & ~trap;
			misaligned_q <= op.instr_misaligned & ~trap;
			illegal_q    <= op.illegal & ~trap;
			ecall_q      <= op.ecall & ~trap;
			ebreak_q     <= op.ebreak & ~trap;
		end
	end

	// interrupt gating by enable and current mode
	assign m_tim = m_tie & m_timer;
	assign m_ext = m_eie & ext_irq;
	assign s_tim = (mode != priv_m) & s_tie & s_timer;
	assign s_ext = (mode != priv_m) & s_eie & ext_irq;
	assign u_tim = (mode == priv_u) & u_tie & u_timer;
	assign u_ext = (mode == priv_u) & u_eie & ext_irq;

	assign trap = m_ext | s_ext | m_tim | s_tim | u_ext | u_tim
		| misaligned_q | illegal_q | ecall_q | ebreak_q;

	// fixed priority with interrupts first
	always_comb
	begin
		is_irq = 1'b1;
		code   = 4'd0;
		if (m_ext)
			code = irq_m_ext;
		else if (s_ext)
			code = irq_s_ext;
		else if (m_tim)
			code = irq_m_timer;
		else if (s_tim)
			code = irq_s_timer;
		else if (u_ext)
			code = irq_u_ext;
		else if (u_tim)
			code = irq_u_timer;
		else
		begin
			is_irq = 1'b0;
			if (misaligned_q)
				code = exc_instr_misaligned;
			else if (illegal_q)
				code = exc_illegal;
			else if (ecall_q)
				code = (mode == priv_u) ? exc_ecall_u :
					(mode == priv_s) ? exc_ecall_s : exc_ecall_m;
			else if (ebreak_q)
				code = exc_breakpoint;
		end
	end

	always_comb
	begin
		cause = '0;
		cause[3:0] = code;
		cause[xlen-1] = is_irq;
	end

	assign wb_data = result_q;
	assign wb_rd   = rd_q;
	assign wb_we   = we_q & ~trap; // trapping instruction never writes
	assign trap_pc = pc_q;

endmodule

`default_nettype wire

// File: exe_execute.sv
`default_nettype none

module exe_execute
	import exe_pkg::*;
#(
	parameter int xlen = 32
) (
	exe_op_if.exec op,
	output logic [xlen-1:0] result,
	output logic redirect,
	output logic [xlen-1:0] target
);

	localparam int sh_w = $clog2(xlen);

	logic [sh_w-1:0] shamt;
	logic [xlen-1:0] alu_res;
	logic [xlen-1:0] jalr_sum;
	logic lt_s;
	logic lt_u;
	logic eq;
	logic taken;

	assign shamt = op.op_b[sh_w-1:0];
	assign lt_s  = $signed(op.op_a) < $signed(op.op_b);
	assign lt_u  = op.op_a < op.op_b;
	assign eq    = op.op_a == op.op_b;

	// integer alu
	always_comb
	begin
		case (op.alu_fn)
			alu_add:  alu_res = op.op_a + op.op_b;
			alu_sub:  alu_res = op.op_a - op.op_b;
			alu_sll:  alu_res = op.op_a << shamt;
			alu_slt:  alu_res = {{(xlen-1){1'b0}}, lt_s};
			alu_sltu: alu_res = {{(xlen-1){1'b0}}, lt_u};
			alu_xor:  alu_res = op.op_a ^ op.op_b;
			alu_srl:  alu_res = op.op_a >> shamt;
			alu_sra:  alu_res = $unsigned($signed(op.op_a) >>> shamt);
			alu_or:   alu_res = op.op_a | op.op_b;
			alu_and:  alu_res = op.op_a & op.op_b;
			default:  alu_res = '0;
		endcase
	end

	// branch compare, shares the comparators with slt/sltu
	always_comb
	begin
		case (op.br_cond)
			br_eq:   taken = eq;
			br_ne:   taken = ~eq;
			br_lt:   taken = lt_s;
			br_ge:   taken = ~lt_s;
			br_ltu:  taken = lt_u;
			br_geu:  taken = ~lt_u;
			default: taken = 1'b0;
		endcase
	end

	assign redirect = (op.is_branch & taken) | op.is_jal | op.is_jalr;

	assign jalr_sum = op.op_a + op.op_b; // rs1 + i_imm

	always_comb
	begin
		if (op.is_jalr)
			target = {jalr_sum[xlen-1:1], 1'b0};
		else if (op.is_jal)
			target = op.pc + op.j_imm;
		else
			target = op.pc + op.b_imm; // only meaningful when redirect is high
	end

	// writeback value
	always_comb
	begin
		case (op.wb_sel)
			wb_alu:   result = alu_res;
			wb_link:  result = op.pc + xlen'(4);
			wb_lui:   result = op.u_imm;
			wb_auipc: result = op.pc + op.u_imm;
			default:  result = alu_res;
		endcase
	end

endmodule

`default_nettype wire

// File: exe_issue_reg.sv
`default_nettype none

module exe_issue_reg
	import exe_pkg::*;
#(
	parameter int xlen = 32
) (
	input  wire logic clk,
	input  wire logic nrst,
	input  wire logic trap, // flush from commit stage
	input  wire logic [xlen-1:0] op_a,
	input  wire logic [xlen-1:0] op_b,
	input  wire logic [xlen-1:0] pc,
	input  wire logic [xlen-1:0] b_imm,
	input  wire logic [xlen-1:0] j_imm,
	input  wire logic [xlen-1:0] u_imm,
	input  wire alu_fn_t alu_fn,
	input  wire br_cond_t br_cond,
	input  wire logic is_branch,
	input  wire logic is_jal,
	input  wire logic is_jalr,
	input  wire wb_sel_t wb_sel,
	input  wire logic [4:0] rd,
	input  wire logic we,
	input  wire logic instr_misaligned,
	input  wire logic illegal,
	input  wire logic ecall,
	input  wire logic ebreak,
	exe_op_if.issue op
);

	// a trap turns whatever is offered this edge into a bubble
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			op.op_a             <= '0;
			op.op_b             <= '0;
			op.pc               <= '0;
			op.b_imm            <= '0;
			op.j_imm            <= '0;
			op.u_imm            <= '0;
			op.alu_fn           <= alu_add;
			op.br_cond          <= br_eq;
			op.is_branch        <= 1'b0;
			op.is_jal           <= 1'b0;
			op.is_jalr          <= 1'b0;
			op.wb_sel           <= wb_alu;
			op.rd               <= '0;
			op.we               <= 1'b0;
			op.instr_misaligned <= 1'b0;
			op.illegal          <= 1'b0;
			op.ecall            <= 1'b0;
			op.ebreak           <= 1'b0;
		end
		else
		begin
			op.op_a             <= trap ? '0 : op_a;
			op.op_b             <= trap ? '0 : op_b;
			op.pc               <= trap ? '0 : pc;
			op.b_imm            <= trap ? '0 : b_imm;
			op.j_imm            <= trap ? '0 : j_imm;
			op.u_imm            <= trap ? '0 : u_imm;
			op.alu_fn           <= trap ? alu_add : alu_fn;
			op.br_cond          <= trap ? br_eq : br_cond;
			op.is_branch        <= is_branch & ~trap;
			op.is_jal           <= is_jal & ~trap;
			op.is_jalr          <= is_jalr & ~trap;
			op.wb_sel           <= trap ? wb_alu : wb_sel;
			op.rd               <= trap ? 5'd0 : rd;
			op.we               <= we & ~trap;
			op.instr_misaligned <= instr_misaligned & ~trap;
			op.illegal          <= illegal & ~trap;
			op.ecall            <= ecall & ~trap;
			op.ebreak           <= ebreak & ~trap;
		end
	end

endmodule

`default_nettype wire

// File: exe_op_if.sv
`default_nettype none

// operand stage contents, valid for one cycle after capture
interface exe_op_if
	import exe_pkg::*;
#(
	parameter int xlen = 32
) ();

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] b_imm;
	logic [xlen-1:0] j_imm;
	logic [xlen-1:0] u_imm;
	alu_fn_t alu_fn;
	br_cond_t br_cond;
	logic is_branch;
	logic is_jal;
	logic is_jalr;
	wb_sel_t wb_sel;
	logic [4:0] rd;
	logic we;
	logic instr_misaligned; // exception flags from decode
	logic illegal;
	logic ecall;
	logic ebreak;

	modport issue (
		output op_a, op_b, pc, b_imm, j_imm, u_imm, alu_fn, br_cond,
		output is_branch, is_jal, is_jalr, wb_sel, rd, we,
		output instr_misaligned, illegal, ecall, ebreak
	);

	modport exec (
		input op_a, op_b, pc, b_imm, j_imm, u_imm, alu_fn, br_cond,
		input is_branch, is_jal, is_jalr, wb_sel
	);

	modport commit (
		input rd, we, pc, instr_misaligned, illegal, ecall, ebreak
	);

endinterface

`default_nettype wire

// File: exe_pkg.sv
`default_nettype none

package exe_pkg;

	// alu operation select
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9
	} alu_fn_t;

	// branch compare, funct3 order not kept
	typedef enum logic [2:0] {
		br_eq  = 3'd0,
		br_ne  = 3'd1,
		br_lt  = 3'd2,
		br_ge  = 3'd3,
		br_ltu = 3'd4,
		br_geu = 3'd5
	} br_cond_t;

	typedef enum logic [1:0] {
		wb_alu   = 2'd0,
		wb_link  = 2'd1, // pc+4
		wb_lui   = 2'd2,
		wb_auipc = 2'd3
	} wb_sel_t;

	typedef enum logic [1:0] {
		priv_u = 2'd0,
		priv_s = 2'd1,
		priv_m = 2'd3 // 2 is reserved
	} priv_mode_t;

	// synchronous causes
	localparam logic [3:0] exc_instr_misaligned = 4'd0;
	localparam logic [3:0] exc_illegal          = 4'd2;
	localparam logic [3:0] exc_breakpoint       = 4'd3;
	localparam logic [3:0] exc_ecall_u          = 4'd8;
	localparam logic [3:0] exc_ecall_s          = 4'd9;
	localparam logic [3:0] exc_ecall_m          = 4'd11;

	// interrupt causes, msb of cause set on top of these
	localparam logic [3:0] irq_u_timer = 4'd4;
	localparam logic [3:0] irq_s_timer = 4'd5;
	localparam logic [3:0] irq_m_timer = 4'd7;
	localparam logic [3:0] irq_u_ext   = 4'd8;
	localparam logic [3:0] irq_s_ext   = 4'd9;
	localparam logic [3:0] irq_m_ext   = 4'd11;

endpackage

`default_nettype wire

// File: exe_top.sv
`default_nettype none

module exe_top
	import exe_pkg::*;
#(
	parameter int xlen = 32
) (
	input  wire logic clk,
	input  wire logic nrst,
	input  wire logic [xlen-1:0] op_a,
	input  wire logic [xlen-1:0] op_b,
	input  wire logic [xlen-1:0] pc,
	input  wire logic [xlen-1:0] b_imm,
	input  wire logic [xlen-1:0] j_imm,
	input  wire logic [xlen-1:0] u_imm,
	input  wire alu_fn_t alu_fn,
	input  wire br_cond_t br_cond,
	input  wire logic is_branch,
	input  wire logic is_jal,
	input  wire logic is_jalr,
	input  wire wb_sel_t wb_sel,
	input  wire logic [4:0] rd,
	input  wire logic we,
	input  wire logic instr_misaligned,
	input  wire logic illegal,
	input  wire logic ecall,
	input  wire logic ebreak,
	input  wire priv_mode_t mode,
	input  wire logic m_timer,
	input  wire logic s_timer,
	input  wire logic u_timer,
	input  wire logic ext_irq,
	input  wire logic m_tie,
	input  wire logic s_tie,
	input  wire logic u_tie,
	input  wire logic m_eie,
	input  wire logic s_eie,
	input  wire logic u_eie,
	output logic redirect,
	output logic [xlen-1:0] target,
	output logic [xlen-1:0] wb_data,
	output logic [4:0] wb_rd,
	output logic wb_we,
	output logic trap,
	output logic [xlen-1:0] cause,
	output logic [xlen-1:0] trap_pc
);

	logic [xlen-1:0] result; // operand stage writeback value

	exe_op_if #(.xlen(xlen)) op_bus ();

	exe_issue_reg #(.xlen(xlen)) u_issue (
		.clk              (clk),
		.nrst             (nrst),
		.trap             (trap),
		.op_a             (op_a),
		.op_b             (op_b),
		.pc               (pc),
		.b_imm            (b_imm),
		.j_imm            (j_imm),
		.u_imm            (u_imm),
		.alu_fn           (alu_fn),
		.br_cond          (br_cond),
		.is_branch        (is_branch),
		.is_jal           (is_jal),
		.is_jalr          (is_jalr),
		.wb_sel           (wb_sel),
		.rd               (rd),
		.we               (we),
		.instr_misaligned (instr_misaligned),
		.illegal          (illegal),
		.ecall            (ecall),
		.ebreak           (ebreak),
		.op               (op_bus.issue)
	);

	exe_execute #(.xlen(xlen)) u_execute (
		.op       (op_bus.exec),
		.result   (result),
		.redirect (redirect),
		.target   (target)
	);

	exe_commit #(.xlen(xlen)) u_commit (
		.clk     (clk),
		.nrst    (nrst),
		.op      (op_bus.commit),
		.result  (result),
		.mode    (mode),
		.m_timer (m_timer),
		.s_timer (s_timer),
		.u_timer (u_timer),
		.ext_irq (ext_irq),
		.m_tie   (m_tie),
		.s_tie   (s_tie),
		.u_tie   (u_tie),
		.m_eie   (m_eie),
		.s_eie   (s_eie),
		.u_eie   (u_eie),
		.wb_data (wb_data),
		.wb_rd   (wb_rd),
		.wb_we   (wb_we),
		.trap    (trap),
		.cause   (cause),
		.trap_pc (trap_pc)
	);

endmodule

`default_nettype wire

// File: tb_exe.sv
`default_nettype none

module tb_exe
	import exe_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int xlen = 32;
	localparam int max_rows = 256;
	localparam int reset_limit = 20;

	typedef struct packed {
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] b_imm;
		logic [xlen-1:0] j_imm;
		logic [xlen-1:0] u_imm;
		alu_fn_t alu_fn;
		br_cond_t br_cond;
		logic is_branch;
		logic is_jal;
		logic is_jalr;
		wb_sel_t wb_sel;
		logic [4:0] rd;
		logic we;
		logic [3:0] exc; // misaligned, illegal, ecall, ebreak
		priv_mode_t mode;
		logic [3:0] irq; // m_timer, s_timer, u_timer, ext_irq
		logic [5:0] ie; // m_tie, s_tie, u_tie, m_eie, s_eie, u_eie
		logic exp_redirect;
		logic [xlen-1:0] exp_target;
		logic [xlen-1:0] exp_wb_data;
		logic exp_wb_we;
		logic [4:0] exp_wb_rd;
		logic exp_trap;
		logic [xlen-1:0] exp_cause;
	} row_t;

	logic clk;
	logic nrst;
	logic [xlen-1:0] op_a, op_b, pc, b_imm, j_imm, u_imm;
	alu_fn_t alu_fn;
	br_cond_t br_cond;
	logic is_branch, is_jal, is_jalr;
	wb_sel_t wb_sel;
	logic [4:0] rd;
	logic we;
	logic instr_misaligned, illegal, ecall, ebreak;
	priv_mode_t mode;
	logic m_timer, s_timer, u_timer, ext_irq;
	logic m_tie, s_tie, u_tie, m_eie, s_eie, u_eie;
	logic redirect;
	logic [xlen-1:0] target;
	logic [xlen-1:0] wb_data;
	logic [4:0] wb_rd;
	logic wb_we;
	logic trap;
	logic [xlen-1:0] cause;
	logic [xlen-1:0] trap_pc;

	row_t rows[$];
	bit flush_issue [max_rows]; // row dropped before the operand stage
	bit flush_commit [max_rows]; // row never reaches the commit stage
	int errors;
	int timeouts;
	integer seed;
	logic reset_ok;

	exe_top #(.xlen(xlen)) u_exe_top (
		.clk (clk), .nrst (nrst),
		.op_a (op_a), .op_b (op_b), .pc (pc),
		.b_imm (b_imm), .j_imm (j_imm), .u_imm (u_imm),
		.alu_fn (alu_fn), .br_cond (br_cond),
		.is_branch (is_branch), .is_jal (is_jal), .is_jalr (is_jalr),
		.wb_sel (wb_sel), .rd (rd), .we (we),
		.instr_misaligned (instr_misaligned), .illegal (illegal),
		.ecall (ecall), .ebreak (ebreak), .mode (mode),
		.m_timer (m_timer), .s_timer (s_timer), .u_timer (u_timer), .ext_irq (ext_irq),
		.m_tie (m_tie), .s_tie (s_tie), .u_tie (u_tie),
		.m_eie (m_eie), .s_eie (s_eie), .u_eie (u_eie),
		.redirect (redirect), .target (target),
		.wb_data (wb_data), .wb_rd (wb_rd), .wb_we (wb_we),
		.trap (trap), .cause (cause), .trap_pc (trap_pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		nrst = 1'b0;
		repeat (3) @(posedge clk);
		nrst <= 1'b1;
	end

	function automatic logic [xlen-1:0] alu_ref(alu_fn_t fn, logic [xlen-1:0] a,
		logic [xlen-1:0] b);
		case (fn)
			alu_add:  return a + b;
			alu_sub:  return a - b;
			alu_sll:  return a << b[4:0];
			alu_slt:  return xlen'($signed(a) < $signed(b));
			alu_sltu: return xlen'(a < b);
			alu_xor:  return a ^ b;
			alu_srl:  return a >> b[4:0];
			alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
			alu_or:   return a | b;
			default:  return a & b;
		endcase
	endfunction

	function automatic logic br_ref(br_cond_t c, logic [xlen-1:0] a, logic [xlen-1:0] b);
		case (c)
			br_eq:   return a == b;
			br_ne:   return a != b;
			br_lt:   return $signed(a) < $signed(b);
			br_ge:   return $signed(a) >= $signed(b);
			br_ltu:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	// {taken, code} of the highest enabled interrupt
	function automatic logic [4:0] irq_ref(row_t r);
		logic s_ok;
		logic u_ok;
		s_ok = r.mode != priv_m;
		u_ok = r.mode == priv_u;
		if (r.ie[2] && r.irq[0])
			return {1'b1, irq_m_ext};
		else if (s_ok && r.ie[1] && r.irq[0])
			return {1'b1, irq_s_ext};
		else if (r.ie[5] && r.irq[3])
			return {1'b1, irq_m_timer};
		else if (s_ok && r.ie[4] && r.irq[2])
			return {1'b1, irq_s_timer};
		else if (u_ok && r.ie[0] && r.irq[0])
			return {1'b1, irq_u_ext};
		else if (u_ok && r.ie[3] && r.irq[1])
			return {1'b1, irq_u_timer};
		return 5'd0;
	endfunction

	function automatic logic [4:0] sync_ref(row_t r);
		if (r.exc[3])
			return {1'b1, exc_instr_misaligned};
		else if (r.exc[2])
			return {1'b1, exc_illegal};
		else if (r.exc[1])
		begin
			if (r.mode == priv_u)
				return {1'b1, exc_ecall_u};
			else if (r.mode == priv_s)
				return {1'b1, exc_ecall_s};
			return {1'b1, exc_ecall_m};
		end
		else if (r.exc[0])
			return {1'b1, exc_breakpoint};
		return 5'd0;
	endfunction

	function automatic row_t blank();
		row_t r;
		r = '0;
		r.mode = priv_m;
		return r;
	endfunction

	task automatic add_row(input row_t r_in);
		row_t r;
		logic [xlen-1:0] sum;
		logic [4:0] irq;
		logic [4:0] exc;
		r = r_in;
		sum = r.op_a + r.op_b;
		r.exp_redirect = (r.is_branch && br_ref(r.br_cond, r.op_a, r.op_b))
			|| r.is_jal || r.is_jalr;
		if (r.is_jalr)
			r.exp_target = {sum[xlen-1:1], 1'b0};
		else if (r.is_jal)
			r.exp_target = r.pc + r.j_imm;
		else
			r.exp_target = r.pc + r.b_imm;
		case (r.wb_sel)
			wb_link:  r.exp_wb_data = r.pc + 32'd4;
			wb_lui:   r.exp_wb_data = r.u_imm;
			wb_auipc: r.exp_wb_data = r.pc + r.u_imm;
			default:  r.exp_wb_data = alu_ref(r.alu_fn, r.op_a, r.op_b);
		endcase
		irq = irq_ref(r);
		exc = sync_ref(r);
		r.exp_trap = irq[4] | exc[4];
		r.exp_cause = irq[4] ? {1'b1, {(xlen-5){1'b0}}, irq[3:0]}
			: {{(xlen-4){1'b0}}, exc[3:0]};
		r.exp_wb_we = r.we & ~r.exp_trap;
		r.exp_wb_rd = r.rd;
		rows.push_back(r);
	endtask

	// a trap candidate with two writing rows behind it
	task automatic trap_group(input row_t r);
		row_t f;
		int k;
		add_row(r);
		for (k = 0; k < 2; k++)
		begin
			f = blank();
			f.op_a = $random(seed);
			f.op_b = $random(seed);
			f.we = 1'b1;
			f.rd = 5'd10;
			add_row(f);
		end
	endtask

	task automatic build_table();
		row_t r;
		int k;
		int p;
		logic [xlen-1:0] pa [3];
		logic [xlen-1:0] pb [3];
		pa[0] = 32'd5;
		pb[0] = 32'd5;
		pa[1] = 32'hffff_fffd;
		pb[1] = 32'd7;
		pa[2] = 32'd7;
		pb[2] = 32'hffff_fffd;
		for (k = 0; k < 10; k++)
		begin
			r = blank();
			r.alu_fn = alu_fn_t'(k);
			r.op_a = $random(seed);
			r.op_b = $random(seed);
			r.we = 1'b1;
			r.rd = 5'(k + 1);
			add_row(r);
		end
		for (k = 0; k < 6; k++)
			for (p = 0; p < 3; p++)
			begin
				r = blank();
				r.is_branch = 1'b1;
				r.br_cond = br_cond_t'(k);
				r.op_a = pa[p];
				r.op_b = pb[p];
				r.pc = 32'h0000_1000 + 32'(k * 16 + p * 4);
				r.b_imm = 32'hffff_ff80; // backward
				add_row(r);
			end
		r = blank();
		r.is_jal = 1'b1;
		r.pc = 32'h0000_2000;
		r.j_imm = 32'h0000_0404;
		r.wb_sel = wb_link;
		r.we = 1'b1;
		r.rd = 5'd1;
		add_row(r);
		r.is_jal = 1'b0;
		r.is_jalr = 1'b1;
		r.op_a = 32'h0000_3001; // odd sum
		r.op_b = 32'h0000_0010;
		add_row(r);
		r = blank();
		r.wb_sel = wb_lui;
		r.u_imm = 32'hdead_b000;
		r.we = 1'b1;
		r.rd = 5'd6;
		add_row(r);
		r.wb_sel = wb_auipc;
		r.pc = 32'h0000_4000;
		add_row(r);
		r = blank();
		r.we = 1'b1;
		r.rd = 5'd3;
		r.pc = 32'h0000_5000;
		r.exc = 4'b1000;
		trap_group(r);
		r.exc = 4'b0100;
		trap_group(r);
		r.exc = 4'b0010;
		r.mode = priv_u;
		trap_group(r);
		r.mode = priv_s;
		trap_group(r);
		r.mode = priv_m;
		trap_group(r);
		r.exc = 4'b0001;
		trap_group(r);
		r.exc = 4'b1110;
		trap_group(r);
		r.exc = 4'b0101;
		trap_group(r);
		r.exc = 4'b0000;
		r.irq = 4'b1000;
		r.ie = 6'b100000;
		trap_group(r);
		r.ie = 6'b000000; // enable off
		trap_group(r);
		r.irq = 4'b0100;
		r.ie = 6'b010000;
		trap_group(r);
		r.mode = priv_s;
		trap_group(r);
		r.irq = 4'b0001;
		r.ie = 6'b000001;
		trap_group(r);
		r.mode = priv_u;
		trap_group(r);
		// everything raised with an illegal instruction, enables peeled off one by one
		r.irq = 4'b1111;
		r.exc = 4'b0100;
		r.ie = 6'b111111;
		trap_group(r);
		r.ie = 6'b111011;
		trap_group(r);
		r.ie = 6'b111001;
		trap_group(r);
		r.ie = 6'b011001;
		trap_group(r);
		r.ie = 6'b001001;
		trap_group(r);
		r.ie = 6'b001000;
		trap_group(r);
		r.ie = 6'b000000;
		trap_group(r);
	endtask

	task automatic drive_instr(input row_t r);
		op_a <= r.op_a;
		op_b <= r.op_b;
		pc <= r.pc;
		b_imm <= r.b_imm;
		j_imm <= r.j_imm;
		u_imm <= r.u_imm;
		alu_fn <= r.alu_fn;
		br_cond <= r.br_cond;
		is_branch <= r.is_branch;
		is_jal <= r.is_jal;
		is_jalr <= r.is_jalr;
		wb_sel <= r.wb_sel;
		rd <= r.rd;
		we <= r.we;
		{instr_misaligned, illegal, ecall, ebreak} <= r.exc;
	endtask

	// mode and interrupts act on the commit stage
	task automatic drive_live(input row_t r);
		mode <= r.mode;
		{m_timer, s_timer, u_timer, ext_irq} <= r.irq;
		{m_tie, s_tie, u_tie, m_eie, s_eie, u_eie} <= r.ie;
	endtask

	task automatic flag_error(input string msg);
		$display("Fail %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_redirect(input int i);
		logic want;
		want = flush_issue[i] ? 1'b0 : rows[i].exp_redirect;
		if (redirect !== want)
			flag_error($sformatf("row %0d redirect %b, expected %b", i, redirect, want));
		if (want && target !== rows[i].exp_target)
			flag_error($sformatf("row %0d target %h, expected %h", i, target,
				rows[i].exp_target));
	endtask

	task automatic check_commit(input int j);
		row_t r;
		logic [4:0] irq;
		logic want_trap;
		logic want_we;
		logic [xlen-1:0] want_cause;
		logic [xlen-1:0] want_pc;
		r = rows[j];
		if (flush_commit[j])
		begin
			irq = irq_ref(r);
			want_trap = irq[4];
			want_cause = {irq[4], {(xlen-5){1'b0}}, irq[3:0]};
			want_we = 1'b0;
			want_pc = '0;
		end
		else
		begin
			want_trap = r.exp_trap;
			want_cause = r.exp_cause;
			want_we = r.exp_wb_we;
			want_pc = r.pc;
		end
		if (wb_we !== want_we)
			flag_error($sformatf("row %0d wb_we %b, expected %b", j, wb_we, want_we));
		if (want_we && (wb_data !== r.exp_wb_data || wb_rd !== r.exp_wb_rd))
			flag_error($sformatf("row %0d wb %h -> x%0d, expected %h -> x%0d", j,
				wb_data, wb_rd, r.exp_wb_data, r.exp_wb_rd));
		if (trap !== want_trap)
			flag_error($sformatf("row %0d trap %b, expected %b", j, trap, want_trap));
		if (want_trap && (cause !== want_cause || trap_pc !== want_pc))
			flag_error($sformatf("row %0d cause %h pc %h, expected %h pc %h", j,
				cause, trap_pc, want_cause, want_pc));
		if (want_trap && j + 2 < max_rows)
		begin
			flush_commit[j+1] = 1'b1;
			flush_commit[j+2] = 1'b1;
			flush_issue[j+2] = 1'b1;
		end
	endtask

	task automatic wait_reset(output logic ok);
		int cycles;
		cycles = 0;
		while (nrst !== 1'b1 && cycles < reset_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		ok = (nrst === 1'b1);
	endtask

	// row c goes in at edge c, its writeback sits behind edge c+2
	task automatic run_table();
		int c;
		int n;
		n = rows.size();
		for (c = 0; c < n + 2; c++)
		begin
			@(posedge clk);
			if (c < n)
				drive_instr(rows[c]);
			else
				drive_instr(blank());
			if (c >= 2)
				drive_live(rows[c-2]);
			else
				drive_live(blank());
			@(negedge clk);
			if (c >= 1 && c <= n)
				check_redirect(c - 1);
			if (c >= 2)
				check_commit(c - 2);
		end
	endtask

	initial
	begin
		errors = 0;
		timeouts = 0;
		seed = 32'h604d_7d97;
		drive_instr(blank());
		drive_live(blank());
		build_table();
		wait_reset(reset_ok);
		if (!reset_ok)
		begin
			$display("reset was not released within %0d cycles", reset_limit);
			timeouts++;
		end
		else
		begin
			@(negedge clk);
			if (redirect !== 1'b0 || wb_we !== 1'b0 || trap !== 1'b0)
				flag_error("outputs not idle after reset");
			run_table();
		end
		$display("%0d rows, %0d errors, %0d timeouts", rows.size(), errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_exe_sva.sv
`default_nettype none

module exe_sva (
	input wire logic clk,
	input wire logic nrst,
	input wire logic trap,
	input wire logic wb_we,
	input wire logic we_q,
	input wire logic misaligned_q,
	input wire logic illegal_q,
	input wire logic ecall_q,
	input wire logic ebreak_q
);

	timeunit 1ns;
	timeprecision 1ps;

	// the row behind a trapping instruction must not write
	no_we_behind_trap: assert property (@(posedge clk) disable iff (!nrst)
		trap |=> !wb_we)
		else $error("wb_we high in the cycle after a trap");

	// commit register is a bubble after a flush
	flush_clears: assert property (@(posedge clk) disable iff (!nrst)
		trap |=> !(we_q || misaligned_q || illegal_q || ecall_q || ebreak_q))
		else $error("commit stage not cleared after trap");

	quiet_in_reset: assert property (@(posedge clk) !nrst |-> !trap)
		else $error("trap high during reset");

endmodule

bind exe_commit exe_sva u_sva (
	.clk          (clk),
	.nrst         (nrst),
	.trap         (trap),
	.wb_we        (wb_we),
	.we_q         (we_q),
	.misaligned_q (misaligned_q),
	.illegal_q    (illegal_q),
	.ecall_q      (ecall_q),
	.ebreak_q     (ebreak_q)
);

`default_nettype wire

// File: verilog.f
exe_pkg.sv
exe_op_if.sv
exe_issue_reg.sv
exe_execute.sv
exe_commit.sv
exe_top.sv
tb_exe_sva.sv
tb_exe.sv
